// File: bench/vicii_properties.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module vicii_properties (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic clk_phi_i,
   input  logic ce_i,
   input  logic rw_i,
   input  logic [`VIC_ADDR_W-1:0] adi_i,
   input  logic [`VIC_DATA_W-1:0] dbi_i,
   input  logic ras_i,
   input  logic cas_i,
   input  logic mux_i,
   input  logic irq_i
);

   import vic_regs_pkg::*;

   // number of failed assertions so far
   int fail_count;
   logic phi_q;
   // raster enable as written over the cpu bus
   logic enable_model;

   initial begin
      fail_count = 0;
   end

   // a write lands on the first tick of phi low
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_q <= 1'b0;
         enable_model <= 1'b0;
      end else begin
         phi_q <= clk_phi_i;
         if (phi_q && !clk_phi_i && !ce_i && !rw_i && adi_i == REG_IRQ_EN) begin
            enable_model <= dbi_i[IRQ_RST_BIT];
         end
      end
   end

   // column strobe only inside an open row
   cas_inside_ras: assert property (@(posedge clk_dot4x) disable iff (rst) !cas_i |-> !ras_i)
      else begin
         $error("cas low while ras high");
         fail_count++;
      end

   // irq line needs the raster enable
   irq_needs_enable: assert property (@(posedge clk_dot4x) disable iff (rst)
                                      irq_i |-> enable_model)
      else begin
         $error("irq asserted with the raster enable clear");
         fail_count++;
      end

   // address mux switches only after the row is latched
   mux_after_ras: assert property (@(posedge clk_dot4x) disable iff (rst) $fell(mux_i) |-> !ras_i)
      else begin
         $error("mux fell before ras");
         fail_count++;
      end

endmodule

bind vicii_top vicii_properties u_vicii_properties (
   .clk_dot4x (clk_dot4x),
   .rst       (rst),
   .clk_phi_i (clk_phi_o),
   .ce_i      (ce_i),
   .rw_i      (rw_i),
   .adi_i     (adi_i),
   .dbi_i     (dbi_i),
   .ras_i     (ras_o),
   .cas_i     (cas_o),
   .mux_i     (mux_o),
   .irq_i     (irq_o)
);

// File: bench/vicii_tb.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module vicii_tb;

   import vic_timing_pkg::*;
   import vic_regs_pkg::*;

   localparam int NUM_CHIPS = 3;
   // a whole 6569 frame is 504 * 312 * 4 ticks
   localparam int FRAME_TIMEOUT = 700000;
   localparam int LINE_TIMEOUT = 4000;
   localparam int BUS_TIMEOUT = 100;
   // one 6569 frame and one more line
   localparam int REFRESH_TIMEOUT = 700000;

   chip_e chip_i;
   logic rst;
   logic clk_dot4x;
   logic [`VIC_ADDR_W-1:0] adi_i;
   logic [`VIC_DATA_W-1:0] dbi_i;
   logic ce_i;
   logic rw_i;
   logic clk_phi_o;
   raster_x_t raster_x_o;
   raster_y_t raster_line_o;
   logic [`VIC_ADO_W-1:0] ado_o;
   logic [`VIC_DATA_W-1:0] dbo_o;
   logic irq_o;
   logic ras_o;
   logic cas_o;
   logic mux_o;

   // one row per chip: type, last pixel, last line
   chip_e chip_tab [NUM_CHIPS] = '{CHIP_6567R8, CHIP_6567R56A, CHIP_6569};
   int x_max_tab [NUM_CHIPS] = '{519, 511, 503};
   int y_max_tab [NUM_CHIPS] = '{262, 261, 311};

   integer seed;

   vicii_top UUT (
      .chip_i        (chip_i),
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .adi_i         (adi_i),
      .dbi_i         (dbi_i),
      .ce_i          (ce_i),
      .rw_i          (rw_i),
      .clk_phi_o     (clk_phi_o),
      .raster_x_o    (raster_x_o),
      .raster_line_o (raster_line_o),
      .ado_o         (ado_o),
      .dbo_o         (dbo_o),
      .irq_o         (irq_o),
      .ras_o         (ras_o),
      .cas_o         (cas_o),
      .mux_o         (mux_o)
   );

   initial begin
      clk_dot4x = 1'b0;
   end

   always #5 clk_dot4x = ~clk_dot4x;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected) begin
         stop_with_failure($sformatf("mismatch at %0t ns: %s got 0x%0h, expected 0x%0h",
                                     $time, name, actual, expected));
      end
   endtask

   // outputs are settled 1 ns after the edge, inputs change there too
   task automatic next_tick();
      @(posedge clk_dot4x);
      #1;
   endtask

   task automatic apply_reset(input chip_e chip);
      chip_i = chip;
      rst = 1'b1;
      repeat (3) next_tick();
      rst = 1'b0;
   endtask

   task automatic wait_phi(input logic level, input string what);
      int n;
      n = 0;
      while (clk_phi_o !== level) begin
         if (n == BUS_TIMEOUT) begin
            stop_with_failure(what);
         end else begin
            next_tick();
            n++;
         end
      end
   endtask

   // write lands at the end of phi high, so hold the bus across one
   task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
      adi_i = addr;
      dbi_i = data;
      rw_i = 1'b0;
      ce_i = 1'b0;
      wait_phi(1'b1, "phi never went high during a register write");
      wait_phi(1'b0, "phi never went low during a register write");
      next_tick();
      ce_i = 1'b1;
      rw_i = 1'b1;
   endtask

   // reads are combinational, data and line are taken together
   task automatic read_reg(input reg_addr_e addr, output logic [7:0] data,
                           output raster_y_t line);
      adi_i = addr;
      rw_i = 1'b1;
      ce_i = 1'b0;
      #1;
      data = dbo_o;
      line = raster_line_o;
      ce_i = 1'b1;
   endtask

   task automatic await_irq(input int limit);
      int n;
      n = 0;
      while (irq_o !== 1'b1) begin
         if (n == limit) begin
            stop_with_failure("irq_o did not rise within a frame");
         end else begin
            next_tick();
            n++;
         end
      end
   endtask

   // irq must stay low the whole time
   task automatic hold_until_line(input raster_y_t line, input logic equal, input int limit,
                                  input string what);
      int n;
      n = 0;
      while ((raster_line_o == line) != equal) begin
         compare_value("irq_o", irq_o, 0);
         if (n == limit) begin
            stop_with_failure(what);
         end else begin
            next_tick();
            n++;
         end
      end
      compare_value("irq_o", irq_o, 0);
   endtask

   // a strobe edge must land on its fixed tick of the half-phase
   task automatic check_strobe_edges(input string name, input logic prev, input logic now,
                                     input int tick, input int fall_tick, input int rise_tick);
      if (prev && !now) begin
         compare_value({name, " fall tick"}, tick, fall_tick);
      end
      if (!prev && now) begin
         compare_value({name, " rise tick"}, tick, rise_tick);
      end
   endtask

   // phi is 16 ticks high, 16 low
   task automatic measure_phi_period();
      int n;
      wait_phi(1'b0, "phi never went low after reset");
      wait_phi(1'b1, "phi never went high after reset");
      n = 0;
      while (clk_phi_o === 1'b1 && n < 40) begin
         next_tick();
         n++;
      end
      compare_value("phi high ticks", n, 16);
      n = 0;
      while (clk_phi_o === 1'b0 && n < 40) begin
         next_tick();
         n++;
      end
      compare_value("phi low ticks", n, 16);
   endtask

   // every pixel lasts 4 ticks, lines and frame wrap at the table limits
   task automatic walk_frame(input int row);
      int n;
      apply_reset(chip_tab[row]);
      n = 0;
      while (raster_x_o !== 1) begin
         if (n == 16) begin
            stop_with_failure("raster_x_o never left 0 after reset");
         end else begin
            next_tick();
            n++;
         end
      end
      for (int y = 0; y <= y_max_tab[row]; y++) begin
         for (int x = (y == 0) ? 1 : 0; x <= x_max_tab[row]; x++) begin
            repeat (4) begin
               compare_value("raster_x_o", raster_x_o, x);
               compare_value("raster_line_o", raster_line_o, y);
               next_tick();
            end
         end
      end
      compare_value("raster_x_o", raster_x_o, 0);
      compare_value("raster_line_o", raster_line_o, 0);
   endtask

   task automatic run_register_tests();
      logic [7:0] rd;
      raster_y_t line;
      raster_y_t cmp;
      integer r;
      apply_reset(CHIP_6569);
      // compare line away from 0, which matches the reset compare
      r = $random(seed);
      cmp = raster_y_t'(2 + ($unsigned(r) % 310));
      write_reg(REG_RASTER, cmp[7:0]);
      write_reg(REG_CTRL1, {cmp[8], 7'h1b});
      read_reg(REG_RASTER, rd, line);
      compare_value("REG_RASTER", rd, line[7:0]);
      read_reg(REG_CTRL1, rd, line);
      compare_value("REG_CTRL1", rd, {line[8], 7'h1b});
      write_reg(REG_IRQ_EN, 8'h01);
      read_reg(REG_IRQ_EN, rd, line);
      compare_value("REG_IRQ_EN", rd, 8'hff);
      write_reg(REG_IRQ_EN, 8'h00);
      read_reg(REG_IRQ_EN, rd, line);
      compare_value("REG_IRQ_EN", rd, 8'hfe);
      // line 0 matched the reset compare, drop that latch
      write_reg(REG_IRQ, 8'h01);
      read_reg(REG_IRQ, rd, line);
      compare_value("REG_IRQ", rd, 8'h7e);
      write_reg(REG_IRQ_EN, 8'h01);
      compare_value("irq_o", irq_o, 0);
      await_irq(FRAME_TIMEOUT);
      compare_value("raster_line_o at irq", raster_line_o, cmp);
      // acknowledge, no second trigger on this line
      write_reg(REG_IRQ, 8'h01);
      compare_value("irq_o", irq_o, 0);
      compare_value("raster_line_o at ack", raster_line_o, cmp);
      hold_until_line(cmp, 1'b0, LINE_TIMEOUT, "raster line never moved past the compare");
      // disabled, the latch still sets for polling
      write_reg(REG_IRQ_EN, 8'h00);
      hold_until_line(cmp, 1'b1, FRAME_TIMEOUT, "compare line did not come round again");
      hold_until_line(cmp, 1'b0, LINE_TIMEOUT, "raster line never moved past the compare");
      read_reg(REG_IRQ, rd, line);
      compare_value("REG_IRQ", rd, 8'h7f);
   endtask

   // refresh row at each ras fall in the phi-low halves of cycles 11..15
   // strobe edges sit on fixed ticks of every half-phase
   task automatic track_refresh();
      int n;
      int samples;
      int lines;
      int tick;
      logic ras_prev;
      logic cas_prev;
      logic mux_prev;
      logic phi_prev;
      raster_y_t line_prev;
      logic [7:0] expect_low;
      apply_reset(CHIP_6569);
      ras_prev = ras_o;
      cas_prev = cas_o;
      mux_prev = mux_o;
      phi_prev = clk_phi_o;
      line_prev = raster_line_o;
      tick = 1;
      n = 0;
      samples = 0;
      lines = 0;
      expect_low = 8'hff;
      // row 2 is the 6569, run one whole frame and line 0 of the next
      while (lines != y_max_tab[2] + 2) begin
         if (n == REFRESH_TIMEOUT) begin
            stop_with_failure("refresh tracking never reached line 1 of the second frame");
         end else begin
            next_tick();
            n++;
         end
         if (clk_phi_o !== phi_prev) begin
            tick = 1;
         end else begin
            tick++;
         end
         check_strobe_edges("ras_o", ras_prev, ras_o, tick, 3, 15);
         check_strobe_edges("cas_o", cas_prev, cas_o, tick, 5, 15);
         check_strobe_edges("mux_o", mux_prev, mux_o, tick, 4, 16);
         if (ras_prev && !ras_o && !clk_phi_o &&
             (raster_x_o / 8) >= 11 && (raster_x_o / 8) <= 15) begin
            // row counter restarts at the top of every frame
            if (raster_line_o == 0 && (raster_x_o / 8) == 11) begin
               expect_low = 8'hff;
            end
            compare_value("ado_o[11:8]", ado_o[11:8], 4'hf);
            compare_value("ado_o[7:0]", ado_o[7:0], expect_low);
            expect_low = expect_low - 8'd1;
            samples++;
         end
         if (raster_line_o !== line_prev) begin
            lines++;
         end
         phi_prev = clk_phi_o;
         ras_prev = ras_o;
         cas_prev = cas_o;
         mux_prev = mux_o;
         line_prev = raster_line_o;
      end
      // five refreshes per line
      compare_value("refresh samples", samples, 5 * lines);
   endtask

   initial begin
      chip_i = CHIP_6569;
      rst = 1'b1;
      adi_i = '0;
      dbi_i = '0;
      ce_i = 1'b1;
      rw_i = 1'b1;
      seed = 41;
      apply_reset(CHIP_6569);
      measure_phi_period();
      for (int row = 0; row < NUM_CHIPS; row++) begin
         walk_frame(row);
      end
      run_register_tests();
      track_refresh();
      if (UUT.u_vicii_properties.fail_count != 0) begin
         stop_with_failure("bound assertions failed during the run");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

// File: common/vic_macros.svh
`ifndef VIC_MACROS_SVH
`define VIC_MACROS_SVH

// pixel counter within a line
`define VIC_RASTER_X_W 10
// raster line counter
`define VIC_RASTER_Y_W 9
// phi cycle number, raster_x / 8
`define VIC_CYCLE_W 7

// clk_dot4x ticks per phi half-phase
`define VIC_HALF_PHASE 16
// clk_dot4x ticks per full phi period
`define VIC_PHI_PERIOD 32

// cycles whose phi-low half is a dram refresh
`define VIC_REFRESH_FIRST 11
`define VIC_REFRESH_LAST 15

// cpu register address bus
`define VIC_ADDR_W 6
// multiplexed dram address bus
`define VIC_ADO_W 12
// cpu data bus
`define VIC_DATA_W 8

`endif

// File: common/vic_regs_pkg.sv
package vic_regs_pkg;

   `include "vic_macros.svh"

   // cpu-visible register map, offsets from $d000
   typedef enum logic [`VIC_ADDR_W-1:0] {
      // control 1, raster compare bit 8 in bit 7
      REG_CTRL1  = 6'h11,
      // raster line low byte / compare low byte
      REG_RASTER = 6'h12,
      // interrupt latch, write 1 to clear
      REG_IRQ    = 6'h19,
      // interrupt enable
      REG_IRQ_EN = 6'h1a
   } reg_addr_e;

   // raster interrupt position in REG_IRQ and REG_IRQ_EN
   localparam int IRQ_RST_BIT = 0;

   // irq line mirror in REG_IRQ
   localparam int IRQ_ANY_BIT = 7;

endpackage

// File: common/vic_timing_pkg.sv
package vic_timing_pkg;

   `include "vic_macros.svh"

   // chip type as strapped on the board
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2,
      CHIP_UNUSED   = 2'd3
   } chip_e;

   // what the current half-cycle is used for
   typedef enum logic [1:0] {
      CYC_IDLE    = 2'd0,
      CYC_REFRESH = 2'd1,
      CYC_CPU     = 2'd2
   } cycle_e;

   typedef logic [`VIC_RASTER_X_W-1:0] raster_x_t;
   typedef logic [`VIC_RASTER_Y_W-1:0] raster_y_t;

   // last pixel of a line; ntsc r8 has 65 cycles, r56a 64, pal 63
   function automatic raster_x_t raster_x_max_of(chip_e chip);
      case (chip)
         CHIP_6567R8:   return raster_x_t'(519);
         CHIP_6567R56A: return raster_x_t'(511);
         default:       return raster_x_t'(503);
      endcase
   endfunction

   // last line of a frame
   function automatic raster_y_t raster_y_max_of(chip_e chip);
      case (chip)
         CHIP_6567R8:   return raster_y_t'(262);
         CHIP_6567R56A: return raster_y_t'(261);
         default:       return raster_y_t'(311);
      endcase
   endfunction

endpackage

// File: logic/cycle_sequencer.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module cycle_sequencer (
   input  logic rst,
   input  logic clk_dot4x,
   input  logic clk_phi_i,
   input  logic phase_start_i,
   input  logic [`VIC_CYCLE_W-1:0] cycle_num_i,
   output vic_timing_pkg::cycle_e cycle_type_o
);

   import vic_timing_pkg::*;

   cycle_e state_q;
   cycle_e state_d;
   logic in_refresh_window;

   // refresh slots sit in the phi-low halves of cycles 11..15
   assign in_refresh_window = (cycle_num_i >= `VIC_CYCLE_W'(`VIC_REFRESH_FIRST)) &&
                              (cycle_num_i <= `VIC_CYCLE_W'(`VIC_REFRESH_LAST));

   // phi already shows the new half-phase level on phase_start
   always_comb begin
      state_d = state_q;
      if (phase_start_i) begin
         if (clk_phi_i) begin
            // high half belongs to the cpu
            state_d = CYC_CPU;
         end else if (in_refresh_window) begin
            state_d = CYC_REFRESH;
         end else begin
            state_d = CYC_IDLE;
         end
      end
   end

   // state is valid from tick 2 of the half-phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         state_q <= CYC_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign cycle_type_o = state_q;

endmodule

// File: logic/dram_refresh.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module dram_refresh (
   input  logic rst,
   input  logic clk_dot4x,
   input  logic phase_start_i,
   input  vic_timing_pkg::cycle_e cycle_type_i,
   input  logic [`VIC_CYCLE_W-1:0] cycle_num_i,
   input  vic_timing_pkg::raster_y_t raster_line_i,
   output logic [`VIC_ADO_W-1:0] ado_o,
   output logic ras_o,
   output logic cas_o,
   output logic mux_o
);

   import vic_timing_pkg::*;

   // strobe shapes, msb first from tick 2, bit 0 is seen on tick 1
   // ras low 3..14
   localparam logic [`VIC_HALF_PHASE-1:0] RAS_PROFILE = 16'b1000_0000_0000_0111;
   // cas low 5..14, always inside ras
   localparam logic [`VIC_HALF_PHASE-1:0] CAS_PROFILE = 16'b1110_0000_0000_0111;
   // mux low 4..15, switches the address between ras and cas
   localparam logic [`VIC_HALF_PHASE-1:0] MUX_PROFILE = 16'b1100_0000_0000_0011;
   // index 0 ras, 1 cas, 2 mux
   localparam logic [2:0][`VIC_HALF_PHASE-1:0] PROFILES = {MUX_PROFILE, CAS_PROFILE, RAS_PROFILE};

   logic [7:0] refc_q;
   logic [2:0][`VIC_HALF_PHASE-1:0] strobe_q;

   // cycle_type still holds the half-cycle that is ending here
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         refc_q <= 8'hff;
      end else if (phase_start_i) begin
         if (cycle_num_i == `VIC_CYCLE_W'(1) && raster_line_i == '0) begin
            refc_q <= 8'hff;
         end else if (cycle_type_i == CYC_REFRESH) begin
            refc_q <= refc_q - 8'd1;
         end
      end
   end

   // profiles restart every half-phase and shift out one bit per tick
   always_ff @(posedge clk_dot4x) begin
      if (rst || phase_start_i) begin
         strobe_q <= PROFILES;
      end else begin
         for (int i = 0; i < 3; i++) begin
            strobe_q[i] <= {strobe_q[i][`VIC_HALF_PHASE-2:0], 1'b0};
         end
      end
   end

   assign ras_o = strobe_q[0][`VIC_HALF_PHASE-1];
   assign cas_o = strobe_q[1][`VIC_HALF_PHASE-1];
   assign mux_o = strobe_q[2][`VIC_HALF_PHASE-1];

   // refresh row on the bus, bus idles high otherwise
   assign ado_o = (cycle_type_i == CYC_REFRESH) ?
                  {{(`VIC_ADO_W-8){1'b1}}, refc_q} : {`VIC_ADO_W{1'b1}};

endmodule

// File: logic/vicii_top.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module vicii_top (
   input  vic_timing_pkg::chip_e chip_i,
   input  logic rst,
   input  logic clk_dot4x,
   input  logic [`VIC_ADDR_W-1:0] adi_i,
   input  logic [`VIC_DATA_W-1:0] dbi_i,
   input  logic ce_i,
   input  logic rw_i,
   output logic clk_phi_o,
   output vic_timing_pkg::raster_x_t raster_x_o,
   output vic_timing_pkg::raster_y_t raster_line_o,
   output logic [`VIC_ADO_W-1:0] ado_o,
   output logic [`VIC_DATA_W-1:0] dbo_o,
   output logic irq_o,
   output logic ras_o,
   output logic cas_o,
   output logic mux_o
);

   import vic_timing_pkg::*;

   // tick markers shared by every block
   logic dot_rise;
   logic phase_start;
   logic [`VIC_CYCLE_W-1:0] cycle_num;
   cycle_e cycle_type;

   phase_gen u_phase_gen (
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .clk_phi_o     (clk_phi_o),
      .dot_rise_o    (dot_rise),
      .phase_start_o (phase_start)
   );

   raster_counter u_raster_counter (
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .chip_i        (chip_i),
      .dot_rise_i    (dot_rise),
      .raster_x_o    (raster_x_o),
      .raster_line_o (raster_line_o),
      .cycle_num_o   (cycle_num)
   );

   cycle_sequencer u_cycle_sequencer (
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .clk_phi_i     (clk_phi_o),
      .phase_start_i (phase_start),
      .cycle_num_i   (cycle_num),
      .cycle_type_o  (cycle_type)
   );

   dram_refresh u_dram_refresh (
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .phase_start_i (phase_start),
      .cycle_type_i  (cycle_type),
      .cycle_num_i   (cycle_num),
      .raster_line_i (raster_line_o),
      .ado_o         (ado_o),
      .ras_o         (ras_o),
      .cas_o         (cas_o),
      .mux_o         (mux_o)
   );

   vic_registers u_vic_registers (
      .rst           (rst),
      .clk_dot4x     (clk_dot4x),
      .clk_phi_i     (clk_phi_o),
      .phase_start_i (phase_start),
      .ce_i          (ce_i),
      .rw_i          (rw_i),
      .adi_i         (adi_i),
      .dbi_i         (dbi_i),
      .raster_line_i (raster_line_o),
      .dbo_o         (dbo_o),
      .irq_o         (irq_o)
   );

endmodule

// File: registers/vic_registers.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module vic_registers (
   input  logic rst,
   input  logic clk_dot4x,
   input  logic clk_phi_i,
   input  logic phase_start_i,
   input  logic ce_i,
   input  logic rw_i,
   input  logic [`VIC_ADDR_W-1:0] adi_i,
   input  logic [`VIC_DATA_W-1:0] dbi_i,
   input  vic_timing_pkg::raster_y_t raster_line_i,
   output logic [`VIC_DATA_W-1:0] dbo_o,
   output logic irq_o
);

   import vic_regs_pkg::*;

   reg_addr_e addr;
   logic phi_prev_q;
   logic wr_stb;
   logic irst_clr;
   logic raster_check;
   // 9-bit raster compare
   logic [`VIC_RASTER_Y_W-1:0] raster_cmp_q;
   // remaining control 1 bits
   logic [6:0] ctrl1_q;
   // raster irq enable
   logic erst_q;
   // raster irq latch
   logic irst_q;
   // once-per-line guard
   logic raster_triggered_q;
   logic [`VIC_DATA_W-1:0] rd_data;

   assign addr = reg_addr_e'(adi_i);

   // phi level one tick back, marks the end of the high phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_prev_q <= 1'b0;
      end else begin
         phi_prev_q <= clk_phi_i;
      end
   end

   // cpu data is stable by the end of phi high
   assign wr_stb = phase_start_i && phi_prev_q && !ce_i && !rw_i;
   assign irst_clr = wr_stb && (addr == REG_IRQ) && dbi_i[IRQ_RST_BIT];

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_cmp_q <= '0;
         ctrl1_q <= '0;
         erst_q <= 1'b0;
      end else if (wr_stb) begin
         case (addr)
            REG_RASTER: raster_cmp_q[7:0] <= dbi_i;
            REG_CTRL1: begin
               raster_cmp_q[8] <= dbi_i[7];
               ctrl1_q <= dbi_i[6:0];
            end
            REG_IRQ_EN: erst_q <= dbi_i[IRQ_RST_BIT];
            default: ;
         endcase
      end
   end

   // compare once per phi cycle, at the start of the high phase
   assign raster_check = phase_start_i && clk_phi_i;

   // latch sets even with the enable clear, so it can be polled
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst_q <= 1'b0;
         raster_triggered_q <= 1'b0;
      end else begin
         if (raster_check) begin
            if (raster_line_i == raster_cmp_q) begin
               if (!raster_triggered_q) begin
                  raster_triggered_q <= 1'b1;
                  irst_q <= 1'b1;
               end
            end else begin
               // line moved on, arm for the next match
               raster_triggered_q <= 1'b0;
            end
         end
         if (irst_clr) begin
            irst_q <= 1'b0;
         end
      end
   end

   // single source, so irq is just latch and enable
   assign irq_o = irst_q & erst_q;

   // unused bits read back as ones
   always_comb begin
      rd_data = {`VIC_DATA_W{1'b1}};
      case (addr)
         REG_RASTER: rd_data = raster_line_i[7:0];
         REG_CTRL1: rd_data = {raster_line_i[8], ctrl1_q};
         REG_IRQ: begin
            rd_data[IRQ_RST_BIT] = irst_q;
            rd_data[IRQ_ANY_BIT] = irq_o;
         end
         REG_IRQ_EN: rd_data[IRQ_RST_BIT] = erst_q;
         default: ;
      endcase
   end

   // combinational read while selected
   assign dbo_o = (!ce_i && rw_i) ? rd_data : {`VIC_DATA_W{1'b1}};

endmodule

// File: src.f
+incdir+common
common/vic_timing_pkg.sv
common/vic_regs_pkg.sv
timing/phase_gen.sv
timing/raster_counter.sv
logic/cycle_sequencer.sv
logic/dram_refresh.sv
registers/vic_registers.sv
logic/vicii_top.sv
bench/vicii_properties.sv
bench/vicii_tb.sv

// File: timing/phase_gen.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module phase_gen (
   input  logic rst,
   input  logic clk_dot4x,
   output logic clk_phi_o,
   output logic dot_rise_o,
   output logic phase_start_o
);

   // all three rings rotate left, bit 0 is the visible output
   // first tick after reset is tick 1 of a phi-low half-phase
   // phi: low for ticks 0..15, high for 16..31
   localparam logic [`VIC_PHI_PERIOD-1:0] PHI_INIT = 32'h0001_fffe;
   // marker on the last tick of each pixel, so raster_x steps
   // exactly on phi boundaries
   localparam logic [3:0] DOT_INIT = 4'b0010;
   // marker on the first tick of each half-phase
   localparam logic [`VIC_HALF_PHASE-1:0] PHASE_INIT = 16'h0001;

   logic [`VIC_PHI_PERIOD-1:0] phi_gen_q;
   logic [3:0] dot_gen_q;
   logic [`VIC_HALF_PHASE-1:0] phase_gen_q;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_gen_q <= PHI_INIT;
         dot_gen_q <= DOT_INIT;
         phase_gen_q <= PHASE_INIT;
      end else begin
         phi_gen_q <= {phi_gen_q[`VIC_PHI_PERIOD-2:0], phi_gen_q[`VIC_PHI_PERIOD-1]};
         dot_gen_q <= {dot_gen_q[2:0], dot_gen_q[3]};
         phase_gen_q <= {phase_gen_q[`VIC_HALF_PHASE-2:0], phase_gen_q[`VIC_HALF_PHASE-1]};
      end
   end

   assign clk_phi_o = phi_gen_q[0];
   assign dot_rise_o = dot_gen_q[0];
   assign phase_start_o = phase_gen_q[0];

endmodule

// File: timing/raster_counter.sv
`timescale 1ns/1ps

`include "vic_macros.svh"

module raster_counter (
   input  logic rst,
   input  logic clk_dot4x,
   input  vic_timing_pkg::chip_e chip_i,
   input  logic dot_rise_i,
   output vic_timing_pkg::raster_x_t raster_x_o,
   output vic_timing_pkg::raster_y_t raster_line_o,
   output logic [`VIC_CYCLE_W-1:0] cycle_num_o
);

   import vic_timing_pkg::*;

   raster_x_t x_max;
   raster_y_t y_max;
   raster_x_t raster_x_q;
   raster_y_t raster_line_q;
   logic x_wrap;
   logic y_wrap;

   // per-chip frame geometry
   assign x_max = raster_x_max_of(chip_i);
   assign y_max = raster_y_max_of(chip_i);

   assign x_wrap = (raster_x_q == x_max);
   assign y_wrap = (raster_line_q == y_max);

   // one pixel per dot; 8 pixels make a phi cycle
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x_q <= '0;
      end else if (dot_rise_i) begin
         if (x_wrap) begin
            raster_x_q <= '0;
         end else begin
            raster_x_q <= raster_x_q + 1'b1;
         end
      end
   end

   // line steps together with the x wrap
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line_q <= '0;
      end else if (dot_rise_i && x_wrap) begin
         if (y_wrap) begin
            raster_line_q <= '0;
         end else begin
            raster_line_q <= raster_line_q + 1'b1;
         end
      end
   end

   assign raster_x_o = raster_x_q;
   assign raster_line_o = raster_line_q;

   // cycle number is the pixel count over 8
   assign cycle_num_o = raster_x_q[`VIC_RASTER_X_W-1:3];

endmodule
